//--- hw/axis_in_pkg.sv
package axis_in_pkg;

   // Stream beat and packed word geometry
   localparam int TDATA_W = 8;
   localparam int WORD_W = 32;
   localparam int N_BEATS = WORD_W / TDATA_W;
   // Beat counter needs at least one bit, even for one beat per word
   localparam int BEAT_CNT_W = (N_BEATS > 1) ? $clog2(N_BEATS) : 1;

   // Word FIFO sizing
   localparam int FIFO_DEPTH_LOG2 = 4;
   localparam int FIFO_DEPTH = 2 ** FIFO_DEPTH_LOG2;
   localparam int LEVEL_W = FIFO_DEPTH_LOG2 + 1;

   // Control register reset values
   localparam int RST_THRESHOLD = 8;

   typedef enum logic {
      ST_WRITE   = 1'b0,
      ST_PADDING = 1'b1
   } axis_state_t;

   // One FIFO entry, strb and last carry one bit per beat slot
   typedef struct packed {
      logic [WORD_W-1:0]  data;
      logic [N_BEATS-1:0] strb;
      logic [N_BEATS-1:0] last;
   } axis_word_t;

   typedef struct packed {
      logic               enable;
      logic               soft_rst;
      logic [LEVEL_W-1:0] threshold;
   } axis_ctrl_t;

endpackage

//--- hw/axis_in_ctrl_fsm.sv
`timescale 1ns/10ps

module axis_in_ctrl_fsm import axis_in_pkg::*; (
   input  logic        clk_i,
   input  logic        rst_i,
   input  axis_ctrl_t  ctrl_i,
   input  logic        tvalid_i,
   input  logic        tlast_i,
   input  logic        word_end_i,
   input  logic        fifo_full_i,
   output logic        tready_o,
   output logic        slot_we_o,
   output logic        pad_o,
   output axis_state_t state_o
);

   axis_state_t state;
   axis_state_t state_nxt;
   logic        can_write;
   logic        beat_accept;

   // Nothing moves while disabled or while the FIFO is full
   assign can_write = ctrl_i.enable & ~fifo_full_i;

   assign tready_o = can_write & (state == ST_WRITE);
   assign beat_accept = tvalid_i & tready_o;

   // Padding fills one slot per cycle without a beat
   assign pad_o = (state == ST_PADDING);
   assign slot_we_o = pad_o ? can_write : beat_accept;

   always_comb begin
      state_nxt = state;
      case (state)
         ST_WRITE: begin
            // Packet ended part-way through a word
            if (beat_accept && tlast_i && !word_end_i) begin
               state_nxt = ST_PADDING;
            end
         end
         ST_PADDING: begin
            if (slot_we_o && word_end_i) begin
               state_nxt = ST_WRITE;
            end
         end
         default: state_nxt = ST_WRITE;
      endcase
   end

   always_ff @(posedge clk_i) begin
      if (rst_i || ctrl_i.soft_rst) begin
         state <= ST_WRITE;
      end else begin
         state <= state_nxt;
      end
   end

   assign state_o = state;

endmodule

//--- hw/axis_beat_counter.sv
`timescale 1ns/10ps

module axis_beat_counter import axis_in_pkg::*; (
   input  logic                  clk_i,
   input  logic                  rst_i,
   input  axis_ctrl_t            ctrl_i,
   input  logic                  slot_we_i,
   output logic [BEAT_CNT_W-1:0] slot_idx_o,
   output logic                  word_end_o
);

   logic [BEAT_CNT_W-1:0] slot_idx;

   assign word_end_o = (slot_idx == BEAT_CNT_W'(N_BEATS - 1));

   always_ff @(posedge clk_i) begin
      if (rst_i || ctrl_i.soft_rst) begin
         slot_idx <= '0;
      end else if (slot_we_i) begin
         // Wrap back to slot 0 once the word is complete
         if (word_end_o) begin
            slot_idx <= '0;
         end else begin
            slot_idx <= slot_idx + 1'b1;
         end
      end
   end

   assign slot_idx_o = slot_idx;

endmodule

//--- hw/axis_word_packer.sv
`timescale 1ns/10ps

module axis_word_packer import axis_in_pkg::*; (
   input  logic                  clk_i,
   input  logic                  rst_i,
   input  axis_ctrl_t            ctrl_i,
   input  logic                  slot_we_i,
   input  logic                  pad_i,
   input  logic [BEAT_CNT_W-1:0] slot_idx_i,
   input  logic                  word_end_i,
   input  logic [TDATA_W-1:0]    tdata_i,
   input  logic                  tlast_i,
   output axis_word_t            word_o,
   output logic                  word_valid_o
);

   axis_word_t hold;
   axis_word_t hold_nxt;

   // Holding register with the current slot merged in
   always_comb begin
      hold_nxt = hold;
      hold_nxt.data[slot_idx_i*TDATA_W +: TDATA_W] = pad_i ? '0 : tdata_i;
      hold_nxt.strb[slot_idx_i] = ~pad_i;
      hold_nxt.last[slot_idx_i] = ~pad_i & tlast_i;
   end

   always_ff @(posedge clk_i) begin
      if (rst_i || ctrl_i.soft_rst) begin
         hold <= '0;
         word_valid_o <= 1'b0;
      end else begin
         word_valid_o <= slot_we_i & word_end_i;
         if (slot_we_i) begin
            // Start the next word from a clean register
            hold <= word_end_i ? '0 : hold_nxt;
         end
      end
   end

   // Finished word, valid for the single cycle after its last slot
   always_ff @(posedge clk_i) begin
      if (slot_we_i && word_end_i) begin
         word_o <= hold_nxt;
      end
   end

endmodule

//--- hw/axis_word_fifo.sv
`timescale 1ns/10ps

module axis_word_fifo import axis_in_pkg::*; (
   input  logic               clk_i,
   input  logic               rst_i,
   input  axis_ctrl_t         ctrl_i,
   input  logic               push_i,
   input  axis_word_t         word_i,
   input  logic               pop_i,
   output axis_word_t         word_o,
   output logic               empty_o,
   output logic               full_o,
   output logic [LEVEL_W-1:0] level_o
);

   axis_word_t                 mem [FIFO_DEPTH];
   logic [FIFO_DEPTH_LOG2-1:0] wr_ptr;
   logic [FIFO_DEPTH_LOG2-1:0] rd_ptr;
   logic [LEVEL_W-1:0]         level;
   logic                       do_push;
   logic                       do_pop;

   assign empty_o = (level == '0);
   assign full_o = (level == LEVEL_W'(FIFO_DEPTH));
   assign level_o = level;

   // Pushes on full and pops on empty are dropped
   assign do_push = push_i & ~full_o;
   assign do_pop = pop_i & ~empty_o;

   always_ff @(posedge clk_i) begin
      if (rst_i || ctrl_i.soft_rst) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         level <= '0;
      end else begin
         if (do_push) begin
            wr_ptr <= wr_ptr + 1'b1;
         end
         if (do_pop) begin
            rd_ptr <= rd_ptr + 1'b1;
         end
         case ({do_push, do_pop})
            2'b10:   level <= level + 1'b1;
            2'b01:   level <= level - 1'b1;
            default: level <= level;
         endcase
      end
   end

   always_ff @(posedge clk_i) begin
      if (do_push) begin
         mem[wr_ptr] <= word_i;
      end
   end

   // Head word stays on the output until the next pop
   always_ff @(posedge clk_i) begin
      if (do_pop) begin
         word_o <= mem[rd_ptr];
      end
   end

endmodule

//--- hw/axis_in_regs.sv
`timescale 1ns/10ps

module axis_in_regs import axis_in_pkg::*; (
   input  logic               clk_i,
   input  logic               rst_i,
   input  logic               enable_i,
   input  logic               soft_rst_i,
   input  logic [LEVEL_W-1:0] threshold_i,
   input  logic               read_i,
   input  logic               fifo_empty_i,
   input  logic [LEVEL_W-1:0] level_i,
   output axis_ctrl_t         ctrl_o,
   output logic               pop_o,
   output logic               rvalid_o,
   output logic               ready_o,
   output logic               threshold_o
);

   logic read_q;
   logic pop_q;

   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         ctrl_o.enable <= 1'b1;
         ctrl_o.soft_rst <= 1'b0;
         ctrl_o.threshold <= LEVEL_W'(RST_THRESHOLD);
         read_q <= 1'b0;
         pop_q <= 1'b0;
         rvalid_o <= 1'b0;
      end else begin
         ctrl_o.enable <= enable_i;
         ctrl_o.soft_rst <= soft_rst_i;
         ctrl_o.threshold <= threshold_i;
         read_q <= read_i;
         // Registered rising edge of the read level, one pop per edge
         pop_q <= read_i & ~read_q;
         // Read data is in the output register one cycle after the pop
         rvalid_o <= pop_q;
      end
   end

   assign pop_o = pop_q;

   assign ready_o = ~fifo_empty_i & ctrl_o.enable;
   assign threshold_o = (level_i >= ctrl_o.threshold);

endmodule

//--- hw/axis_in_top.sv
`timescale 1ns/10ps

module axis_in_top import axis_in_pkg::*; (
   input  logic               clk_i,
   input  logic               rst_i,
   input  logic [TDATA_W-1:0] tdata_i,
   input  logic               tvalid_i,
   input  logic               tlast_i,
   output logic               tready_o,
   input  logic               enable_i,
   input  logic               soft_rst_i,
   input  logic [LEVEL_W-1:0] threshold_i,
   input  logic               read_i,
   output logic [WORD_W-1:0]  data_o,
   output logic [N_BEATS-1:0] strb_o,
   output logic               last_o,
   output logic               rvalid_o,
   output logic               ready_o,
   output logic [LEVEL_W-1:0] level_o,
   output logic               threshold_o
);

   axis_ctrl_t            ctrl;
   axis_state_t           state;
   axis_word_t            packed_word;
   axis_word_t            rd_word;
   logic                  slot_we;
   logic                  pad;
   logic [BEAT_CNT_W-1:0] slot_idx;
   logic                  word_end;
   logic                  word_valid;
   logic                  fifo_full;
   logic                  fifo_empty;
   logic                  pop;

   axis_in_ctrl_fsm u_fsm (
      .clk_i       (clk_i),
      .rst_i       (rst_i),
      .ctrl_i      (ctrl),
      .tvalid_i    (tvalid_i),
      .tlast_i     (tlast_i),
      .word_end_i  (word_end),
      .fifo_full_i (fifo_full),
      .tready_o    (tready_o),
      .slot_we_o   (slot_we),
      .pad_o       (pad),
      .state_o     (state)
   );

   axis_beat_counter u_counter (
      .clk_i      (clk_i),
      .rst_i      (rst_i),
      .ctrl_i     (ctrl),
      .slot_we_i  (slot_we),
      .slot_idx_o (slot_idx),
      .word_end_o (word_end)
   );

   axis_word_packer u_packer (
      .clk_i        (clk_i),
      .rst_i        (rst_i),
      .ctrl_i       (ctrl),
      .slot_we_i    (slot_we),
      .pad_i        (pad),
      .slot_idx_i   (slot_idx),
      .word_end_i   (word_end),
      .tdata_i      (tdata_i),
      .tlast_i      (tlast_i),
      .word_o       (packed_word),
      .word_valid_o (word_valid)
   );

   axis_word_fifo u_fifo (
      .clk_i   (clk_i),
      .rst_i   (rst_i),
      .ctrl_i  (ctrl),
      .push_i  (word_valid),
      .word_i  (packed_word),
      .pop_i   (pop),
      .word_o  (rd_word),
      .empty_o (fifo_empty),
      .full_o  (fifo_full),
      .level_o (level_o)
   );

   axis_in_regs u_regs (
      .clk_i        (clk_i),
      .rst_i        (rst_i),
      .enable_i     (enable_i),
      .soft_rst_i   (soft_rst_i),
      .threshold_i  (threshold_i),
      .read_i       (read_i),
      .fifo_empty_i (fifo_empty),
      .level_i      (level_o),
      .ctrl_o       (ctrl),
      .pop_o        (pop),
      .rvalid_o     (rvalid_o),
      .ready_o      (ready_o),
      .threshold_o  (threshold_o)
   );

   // Word fields out to the processor port
   assign data_o = rd_word.data;
   assign strb_o = rd_word.strb;
   assign last_o = |rd_word.last;

endmodule

//--- tests/axis_in_assertions.sv
`timescale 1ns/10ps

module axis_in_assertions import axis_in_pkg::*; (
   input logic               clk_i,
   input logic               rst_i,
   input axis_state_t        state_i,
   input logic               fifo_full_i,
   input logic               tready_i,
   input logic               read_i,
   input logic               rvalid_i,
   input logic [LEVEL_W-1:0] level_i
);

   // No beat may be taken while padding or with the FIFO full
   tready_blocked: assert property (@(posedge clk_i) disable iff (rst_i)
      (state_i == ST_PADDING || fifo_full_i) |-> !tready_i)
      else $error("tready_o high during padding or while the FIFO is full");

   // Edge detect plus registered read gives exactly two cycles
   read_to_rvalid: assert property (@(posedge clk_i) disable iff (rst_i)
      $rose(read_i) |-> ##2 rvalid_i)
      else $error("rvalid_o missing two cycles after a read_i rising edge");

   rvalid_from_edge: assert property (@(posedge clk_i) disable iff (rst_i)
      rvalid_i |-> $past(read_i, 2) && !$past(read_i, 3))
      else $error("rvalid_o pulse without a read_i rising edge two cycles earlier");

   level_bound: assert property (@(posedge clk_i) disable iff (rst_i)
      level_i <= LEVEL_W'(FIFO_DEPTH))
      else $error("level_o above the FIFO depth");

endmodule

bind axis_in_top axis_in_assertions u_assertions (
   .clk_i       (clk_i),
   .rst_i       (rst_i),
   .state_i     (state),
   .fifo_full_i (fifo_full),
   .tready_i    (tready_o),
   .read_i      (read_i),
   .rvalid_i    (rvalid_o),
   .level_i     (level_o)
);

//--- tests/axis_in_tb.sv
`timescale 1ns/10ps

module axis_in_tb import axis_in_pkg::*; ();

   localparam int PKT_WHOLE = 8;
   localparam int PKT_PAD = 12;
   localparam int PKT_FULL = 20;
   localparam int PKT_OTHER = 9;
   // Forty cycles per packet, ten spare packets cover reset and settling
   localparam int TIMEOUT_CYCLES = (PKT_WHOLE + PKT_PAD + PKT_FULL + PKT_OTHER + 10) * 40;

   logic               clk_i = 1'b0;
   logic               rst_i;
   logic [TDATA_W-1:0] tdata_i;
   logic               tvalid_i;
   logic               tlast_i;
   logic               tready_o;
   logic               enable_i;
   logic               soft_rst_i;
   logic [LEVEL_W-1:0] threshold_i;
   logic               read_i;
   logic [WORD_W-1:0]  data_o;
   logic [N_BEATS-1:0] strb_o;
   logic               last_o;
   logic               rvalid_o;
   logic               ready_o;
   logic [LEVEL_W-1:0] level_o;
   logic               threshold_o;

   integer                seed = 32'h978a1fb9;
   axis_word_t            exp_q[$];
   axis_word_t            cur_word;
   logic [BEAT_CNT_W-1:0] cur_slot;
   int                    errors = 0;
   int                    err_mark = 0;
   int                    tests_run = 0;
   int                    tests_failed = 0;
   int                    cycle_cnt = 0;

   axis_in_top UUT (.*);

   always #4 clk_i = ~clk_i;

   always @(posedge clk_i) begin
      cycle_cnt++;
      if (cycle_cnt >= TIMEOUT_CYCLES) begin
         $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
         $display("Simulation FAILED");
         $finish;
      end
   end

   task automatic compare_val(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
      assert (got === exp) else begin
         $display("ERROR %0t %s: got %h, expected %h", $time, name, got, exp);
         errors++;
      end
   endtask

   task automatic require(input string what, input logic cond);
      assert (cond === 1'b1) else begin
         $display("%0t: %s", $time, what);
         errors++;
      end
   endtask

   // Reference packing, a packet end closes the word and leaves the rest zero
   task automatic model_beat(input logic [TDATA_W-1:0] data, input logic last);
      cur_word.data[cur_slot*TDATA_W +: TDATA_W] = data;
      cur_word.strb[cur_slot] = 1'b1;
      cur_word.last[cur_slot] = last;
      if (cur_slot == BEAT_CNT_W'(N_BEATS - 1) || last) begin
         exp_q.push_back(cur_word);
         cur_word = '0;
         cur_slot = '0;
      end else begin
         cur_slot = cur_slot + 1'b1;
      end
   endtask

   task automatic send_beat(input logic [TDATA_W-1:0] data, input logic last);
      @(negedge clk_i);
      tdata_i = data;
      tlast_i = last;
      tvalid_i = 1'b1;
      // tready_o only depends on registers, so it is settled here
      while (!tready_o) begin
         @(negedge clk_i);
      end
      model_beat(data, last);
   endtask

   task automatic send_packet(input int len, input bit gaps);
      int gap;
      for (int i = 0; i < len; i++) begin
         gap = gaps ? ($random(seed) & 3) : 0;
         repeat (gap) begin
            @(negedge clk_i);
            tvalid_i = 1'b0;
         end
         send_beat(TDATA_W'($random(seed)), i == len - 1);
      end
      @(negedge clk_i);
      tvalid_i = 1'b0;
      tlast_i = 1'b0;
   endtask

   task automatic read_word(input int hold);
      axis_word_t exp;
      int         cycles;
      @(negedge clk_i);
      read_i = 1'b1;
      cycles = 0;
      do begin
         @(negedge clk_i);
         cycles++;
      end while (!rvalid_o && cycles < 8);
      require("rvalid_o did not follow the read_i edge by 2 cycles", cycles == 2 && rvalid_o);
      if (exp_q.size() == 0) begin
         require("a word was read while the model queue was empty", 1'b0);
      end else begin
         exp = exp_q.pop_front();
         compare_val("data_o", data_o, exp.data);
         compare_val("strb_o", 32'(strb_o), 32'(exp.strb));
         compare_val("last_o", 32'(last_o), 32'(|exp.last));
      end
      repeat (hold) begin
         @(negedge clk_i);
         require("a second rvalid_o pulse came while read_i was held", !rvalid_o);
      end
      read_i = 1'b0;
   endtask

   task automatic drain_words(input int n, input bit gaps);
      int done;
      done = 0;
      while (done < n) begin
         if (ready_o && (!gaps || ($random(seed) & 1))) begin
            read_word($random(seed) & 3);
            done++;
         end else begin
            @(negedge clk_i);
         end
      end
   endtask

   task automatic wait_level(input int n);
      int cycles;
      cycles = 0;
      while (level_o != LEVEL_W'(n) && cycles < 200) begin
         @(negedge clk_i);
         cycles++;
      end
      require("level_o did not reach the expected count in time", level_o == LEVEL_W'(n));
   endtask

   // Streams random packets while a reader pops words at random moments
   task automatic stream_and_read(input int npkt, input bit whole);
      int lens[$];
      int words;
      words = 0;
      for (int p = 0; p < npkt; p++) begin
         if (whole) begin
            lens.push_back(N_BEATS * (1 + ($random(seed) & 1)));
         end else begin
            lens.push_back(1 + {$random(seed)} % 10);
         end
         words += (lens[p] + N_BEATS - 1) / N_BEATS;
      end
      fork
         foreach (lens[p]) send_packet(lens[p], 1'b1);
         drain_words(words, 1'b1);
      join
   endtask

   task automatic report_test(input string name);
      tests_run++;
      if (errors == err_mark) begin
         $display("Test %0d %s: passed", tests_run, name);
      end else begin
         tests_failed++;
         $display("Test %0d %s: failed with %0d errors", tests_run, name, errors - err_mark);
      end
      err_mark = errors;
   endtask

   initial begin
      rst_i = 1'b1;
      tdata_i = '0;
      tvalid_i = 1'b0;
      tlast_i = 1'b0;
      enable_i = 1'b1;
      soft_rst_i = 1'b0;
      threshold_i = LEVEL_W'(RST_THRESHOLD);
      read_i = 1'b0;
      cur_word = '0;
      cur_slot = '0;
      repeat (16) @(negedge clk_i);
      compare_val("ready_o", 32'(ready_o), 32'd0);
      compare_val("rvalid_o", 32'(rvalid_o), 32'd0);
      compare_val("level_o", 32'(level_o), 32'd0);
      rst_i = 1'b0;
      report_test("reset");

      stream_and_read(PKT_WHOLE, 1'b1);
      report_test("whole words");

      stream_and_read(PKT_PAD, 1'b0);
      report_test("padding");

      // No reads until the FIFO is full, then drain everything
      fork
         for (int p = 0; p < PKT_FULL; p++) send_packet(N_BEATS, 1'b0);
         begin
            wait_level(FIFO_DEPTH);
            repeat (8) begin
               @(negedge clk_i);
               compare_val("tready_o", 32'(tready_o), 32'd0);
            end
            compare_val("level_o", 32'(level_o), FIFO_DEPTH);
            drain_words(PKT_FULL, 1'b0);
         end
      join
      report_test("back-pressure");

      send_packet(N_BEATS, 1'b0);
      send_packet(N_BEATS, 1'b0);
      wait_level(2);
      compare_val("ready_o", 32'(ready_o), 32'(exp_q.size() != 0));
      read_word(5);
      compare_val("level_o", 32'(level_o), 32'd1);
      read_word(0);
      compare_val("level_o", 32'(level_o), 32'd0);
      compare_val("ready_o", 32'(ready_o), 32'(exp_q.size() != 0));
      report_test("read port");

      send_packet(N_BEATS, 1'b0);
      wait_level(1);
      @(negedge clk_i);
      enable_i = 1'b0;
      // Offer a beat only once the registered enable has dropped
      @(negedge clk_i);
      tdata_i = TDATA_W'(8'h5a);
      tlast_i = 1'b1;
      tvalid_i = 1'b1;
      repeat (6) begin
         @(negedge clk_i);
         compare_val("tready_o", 32'(tready_o), 32'd0);
         compare_val("ready_o", 32'(ready_o), 32'd0);
      end
      tvalid_i = 1'b0;
      tlast_i = 1'b0;
      compare_val("level_o", 32'(level_o), 32'd1);
      enable_i = 1'b1;
      @(negedge clk_i);
      compare_val("ready_o", 32'(ready_o), 32'd1);
      soft_rst_i = 1'b1;
      @(negedge clk_i);
      soft_rst_i = 1'b0;
      wait_level(0);
      exp_q.delete();
      compare_val("ready_o", 32'(ready_o), 32'd0);
      report_test("enable and soft reset");

      for (int p = 0; p < 6; p++) send_packet(N_BEATS, 1'b1);
      wait_level(6);
      repeat (12) begin
         @(negedge clk_i);
         threshold_i = LEVEL_W'({$random(seed)} % (FIFO_DEPTH + 1));
         @(negedge clk_i);
         compare_val("level_o", 32'(level_o), 32'(exp_q.size()));
         compare_val("threshold_o", 32'(threshold_o),
                     32'(exp_q.size() >= int'(threshold_i)));
         if (ready_o && ($random(seed) & 1)) begin
            read_word(0);
         end
      end
      drain_words(exp_q.size(), 1'b0);
      threshold_i = LEVEL_W'(RST_THRESHOLD);
      report_test("threshold");

      $display("Tests run %0d, tests failed %0d, errors %0d", tests_run, tests_failed, errors);
      if (tests_failed == 0) begin
         $display("Simulation PASSED");
      end else begin
         $display("Simulation FAILED");
      end
      $finish;
   end

endmodule

//--- src.f
hw/axis_in_pkg.sv
hw/axis_in_ctrl_fsm.sv
hw/axis_beat_counter.sv
hw/axis_word_packer.sv
hw/axis_word_fifo.sv
hw/axis_in_regs.sv
hw/axis_in_top.sv
tests/axis_in_assertions.sv
tests/axis_in_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the axis_in testbench with Verilator
set -u
cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir

verilator --binary --timing --assert --timescale 1ns/10ps \
   --top-module axis_in_tb -Mdir "$OBJ" -f src.f
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   exit 1
fi

"./$OBJ/Vaxis_in_tb" | tee "$LOG"
if [ "${PIPESTATUS[0]}" -ne 0 ]; then
   echo "Simulation executable returned an error"
   exit 1
fi

if grep -q "Simulation FAILED" "$LOG"; then
   exit 1
fi
exit 0
